// File: common/vdma_params.svh
`ifndef VDMA_PARAMS_SVH
`define VDMA_PARAMS_SVH

// bus and pixel widths
`define VDMA_PIX_W        32
`define VDMA_BEAT_W       128
`define VDMA_ADDR_W       32
`define VDMA_OFS_W        16
`define VDMA_BUF_W        8
`define VDMA_SIZE_W       16

// frame geometry
`define VDMA_BASE_ADDR    32'h1000_0000
`define VDMA_XSIZE        16               // pixels per line
`define VDMA_XSTRIDE      32               // line pitch in pixels
`define VDMA_YSIZE        4
`define VDMA_XDIV         2                // bursts per line
`define VDMA_NBUF         3

// fifo and timing
`define VDMA_FIFO_DEPTH   64               // in pixels
`define VDMA_FLUSH_CYC    8
`define VDMA_RST_CYC      16
`define VDMA_IRQ_CYC      60

// derived
`define VDMA_PACK_N       ((`VDMA_BEAT_W) / (`VDMA_PIX_W))
`define VDMA_FIFO_BEATS   ((`VDMA_FIFO_DEPTH) / (`VDMA_PACK_N))
`define VDMA_FIFO_AW      ($clog2(`VDMA_FIFO_BEATS))
`define VDMA_CNT_W        ((`VDMA_FIFO_AW) + 1)
`define VDMA_BURST_BEATS  (((`VDMA_XSIZE) / (`VDMA_PACK_N)) / (`VDMA_XDIV))
`define VDMA_BURST_INC    (((`VDMA_XSIZE) * ((`VDMA_PIX_W) / 8)) / (`VDMA_XDIV))
`define VDMA_LINE_INC     ((((`VDMA_XSTRIDE) - (`VDMA_XSIZE)) * ((`VDMA_PIX_W) / 8)) + `VDMA_BURST_INC)
`define VDMA_BURSTS       ((`VDMA_YSIZE) * (`VDMA_XDIV))

`endif

// File: common/vdma_pkg.sv
`include "vdma_params.svh"

package vdma_pkg;

  typedef logic [`VDMA_PIX_W-1:0]  pixel_t;
  typedef logic [`VDMA_BEAT_W-1:0] beat_t;
  typedef logic [`VDMA_ADDR_W-1:0] addr_t;
  typedef logic [`VDMA_OFS_W-1:0]  ofs_t;    // byte offset inside one frame
  typedef logic [`VDMA_BUF_W-1:0]  buf_idx_t;
  typedef logic [`VDMA_CNT_W-1:0]  fifo_cnt_t; // beats held in the fifo
  typedef logic [`VDMA_SIZE_W-1:0] bsize_t;

  typedef enum logic [1:0] {
    IDLE,
    FLUSH,  // fifo flush and settle after frame start
    REQ,
    BUSY
  } burst_state_e;

  typedef struct packed {
    addr_t  addr;
    bsize_t size;  // burst length in beats
  } wr_cmd_t;

endpackage

// File: design/frame_sync_detect.sv
`include "vdma_params.svh"

module frame_sync_detect (
  input  logic ui_clk,
  input  logic ui_rstn,
  input  logic fs_i,
  output logic frame_start_o
);

  logic [1:0] fs_sync_q;  // two-flop synchronizer
  logic       fs_edge_q;  // previous synchronized level

  always_ff @(posedge ui_clk) begin
    if (!ui_rstn) begin
      fs_sync_q     <= '0;
      fs_edge_q     <= 1'b0;
      frame_start_o <= 1'b0;
    end else begin
      fs_sync_q     <= {fs_sync_q[0], fs_i};
      fs_edge_q     <= fs_sync_q[1];
      frame_start_o <= fs_sync_q[1] && !fs_edge_q; // rising edge only
    end
  end

endmodule

// File: design/pixel_pack_fifo.sv
`include "vdma_params.svh"

module pixel_pack_fifo (
  input  logic                ui_clk,
  input  logic                ui_rstn,
  input  logic                flush_i,
  input  logic                pixel_vld_i,
  input  vdma_pkg::pixel_t    pixel_i,
  output logic                full_o,
  input  logic                rd_i,
  output vdma_pkg::beat_t     beat_o,
  output vdma_pkg::fifo_cnt_t beat_cnt_o
);

  vdma_pkg::beat_t mem [`VDMA_FIFO_BEATS];

  logic [`VDMA_FIFO_AW:0]             wr_ptr_q;  // msb is the wrap bit
  logic [`VDMA_FIFO_AW:0]             rd_ptr_q;
  logic [$clog2(`VDMA_PACK_N)-1:0]    pack_idx_q;
  vdma_pkg::beat_t                    pack_q;    // partial beat being gathered
  vdma_pkg::beat_t                    pack_nxt;
  logic                               pix_acc;
  logic                               pack_last;

  assign beat_cnt_o = wr_ptr_q - rd_ptr_q;
  assign full_o     = (beat_cnt_o == vdma_pkg::fifo_cnt_t'(`VDMA_FIFO_BEATS));
  assign pix_acc    = pixel_vld_i && !full_o && !flush_i;
  assign pack_last  = (pack_idx_q == ($clog2(`VDMA_PACK_N))'(`VDMA_PACK_N - 1));

  // first pixel of a group lands in the low bits
  always_comb begin
    pack_nxt = pack_q;
    pack_nxt[pack_idx_q*`VDMA_PIX_W +: `VDMA_PIX_W] = pixel_i;
  end

  always_ff @(posedge ui_clk) begin
    if (!ui_rstn || flush_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      pack_idx_q <= '0;
    end else begin
      if (pix_acc) begin
        if (pack_last) begin
          pack_idx_q <= '0;
          wr_ptr_q   <= wr_ptr_q + 1'b1;
        end else begin
          pack_idx_q <= pack_idx_q + 1'b1;
        end
      end
      if (rd_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge ui_clk) begin
    if (pix_acc) begin
      pack_q <= pack_nxt;
    end
    if (pix_acc && pack_last) begin
      mem[wr_ptr_q[`VDMA_FIFO_AW-1:0]] <= pack_nxt; // complete beat
    end
  end

  assign beat_o = mem[rd_ptr_q[`VDMA_FIFO_AW-1:0]]; // fall-through read

  // the dma engine only pulses wvalid once a burst worth of beats is stored
  a_no_empty_read: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
    (rd_i && !flush_i) |-> (beat_cnt_o != '0))
    else $error("beat read from empty fifo");

  a_no_write_full: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
    pixel_vld_i |-> !full_o)
    else $error("pixel written while fifo full, pixel dropped");

endmodule

// File: design/vdma_frame_writer.sv
`include "vdma_params.svh"

module vdma_frame_writer (
  input  logic                ui_clk,
  input  logic                ui_rstn,
  input  logic                fs_i,
  input  logic                pixel_vld_i,
  input  vdma_pkg::pixel_t    pixel_i,
  output logic                full_o,
  input  vdma_pkg::buf_idx_t  buf_sel_i,
  output vdma_pkg::buf_idx_t  sync_cnt_o,
  output vdma_pkg::buf_idx_t  wbuf_o,
  output vdma_pkg::wr_cmd_t   fdma_cmd_o,
  output logic                fdma_areq_o,
  input  logic                fdma_busy_i,
  input  logic                fdma_wvalid_i,
  output vdma_pkg::beat_t     fdma_wdata_o,
  output logic                fdma_irq_o
);

  logic                frame_start;
  logic                flush;
  vdma_pkg::fifo_cnt_t beat_cnt;

  frame_sync_detect u_sync (
    .ui_clk        (ui_clk),
    .ui_rstn       (ui_rstn),
    .fs_i          (fs_i),
    .frame_start_o (frame_start)
  );

  pixel_pack_fifo u_fifo (
    .ui_clk      (ui_clk),
    .ui_rstn     (ui_rstn),
    .flush_i     (flush),
    .pixel_vld_i (pixel_vld_i),
    .pixel_i     (pixel_i),
    .full_o      (full_o),
    .rd_i        (fdma_wvalid_i),  // each wvalid consumes one beat
    .beat_o      (fdma_wdata_o),
    .beat_cnt_o  (beat_cnt)
  );

  burst_sequencer u_seq (
    .ui_clk        (ui_clk),
    .ui_rstn       (ui_rstn),
    .frame_start_i (frame_start),
    .buf_sel_i     (buf_sel_i),
    .beat_cnt_i    (beat_cnt),
    .busy_i        (fdma_busy_i),
    .flush_o       (flush),
    .areq_o        (fdma_areq_o),
    .cmd_o         (fdma_cmd_o),
    .irq_o         (fdma_irq_o),
    .sync_cnt_o    (sync_cnt_o),
    .wbuf_o        (wbuf_o)
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vdma_frame_writer -f verilog.f \
  && ./obj_dir/Vtb_vdma_frame_writer | tee /dev/stderr \
  | grep -q "Test completed successfully" \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }

// File: test/tb_dma_model.sv
`include "vdma_params.svh"

module tb_dma_model (
  input  logic              ui_clk,
  input  logic              areq_i,
  input  vdma_pkg::wr_cmd_t cmd_i,
  input  vdma_pkg::beat_t   wdata_i,
  output logic              busy_o,
  output logic              wvalid_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_BURSTS = 32;
  localparam int MAX_BEATS  = MAX_BURSTS * `VDMA_BURST_BEATS;

  vdma_pkg::addr_t  addr_log [MAX_BURSTS];
  vdma_pkg::bsize_t size_log [MAX_BURSTS];
  logic             areq_log [MAX_BURSTS];  // areq level once busy was seen
  vdma_pkg::beat_t  beat_log [MAX_BEATS];
  int               n_bursts;
  int               n_beats;
  integer           seed;

  // outputs sampled on the falling edge, driven on the rising edge
  initial begin : responder
    int delay;
    int i;
    seed     = 32'hb845_bd1a;
    n_bursts = 0;
    n_beats  = 0;
    busy_o   = 1'b0;
    wvalid_o = 1'b0;
    forever begin
      @(negedge ui_clk);
      if (areq_i && n_bursts < MAX_BURSTS) begin
        delay = $unsigned($random(seed)) % 8;
        addr_log[n_bursts] = cmd_i.addr;
        size_log[n_bursts] = cmd_i.size;
        repeat (delay) @(posedge ui_clk);
        @(posedge ui_clk);
        busy_o <= 1'b1;
        @(posedge ui_clk);  // sequencer sees busy here
        @(negedge ui_clk);
        areq_log[n_bursts] = areq_i;
        for (i = 0; i < `VDMA_BURST_BEATS; i++) begin
          @(posedge ui_clk);
          wvalid_o <= 1'b1;
          @(negedge ui_clk);
          beat_log[n_beats] = wdata_i;  // beat consumed on next edge
          n_beats++;
        end
        @(posedge ui_clk);
        wvalid_o <= 1'b0;
        busy_o   <= 1'b0;
        n_bursts++;
      end
    end
  end

endmodule

// File: test/tb_vdma_frame_writer.sv
`include "vdma_params.svh"

module tb_vdma_frame_writer;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 40;
  localparam int N_FRAMES    = 3;
  localparam int FRAME_PIX   = `VDMA_XSIZE * `VDMA_YSIZE;
  localparam int FRAME_BEATS = FRAME_PIX / `VDMA_PACK_N;
  localparam int FRAME_CYC   = 40 + FRAME_PIX * 4 + `VDMA_BURSTS * 16 + `VDMA_IRQ_CYC;
  localparam int TIMEOUT_CYC = 10 + N_FRAMES * FRAME_CYC + 500;

  logic               ui_clk;
  logic               ui_rstn;
  logic               fs;
  logic               pixel_vld;
  vdma_pkg::pixel_t   pixel;
  logic               full;
  vdma_pkg::buf_idx_t buf_sel;
  vdma_pkg::buf_idx_t sync_cnt;
  vdma_pkg::buf_idx_t wbuf;
  vdma_pkg::wr_cmd_t  cmd;
  logic               areq;
  logic               busy;
  logic               wvalid;
  vdma_pkg::beat_t    wdata;
  logic               irq;

  integer             seed;
  int                 n_errors;
  int                 n_checks;
  int                 n_pix;
  int                 exp_sync;  // expected ring position
  vdma_pkg::pixel_t   pix_log [N_FRAMES * FRAME_PIX];

  vdma_frame_writer u_dut (
    .ui_clk        (ui_clk),
    .ui_rstn       (ui_rstn),
    .fs_i          (fs),
    .pixel_vld_i   (pixel_vld),
    .pixel_i       (pixel),
    .full_o        (full),
    .buf_sel_i     (buf_sel),
    .sync_cnt_o    (sync_cnt),
    .wbuf_o        (wbuf),
    .fdma_cmd_o    (cmd),
    .fdma_areq_o   (areq),
    .fdma_busy_i   (busy),
    .fdma_wvalid_i (wvalid),
    .fdma_wdata_o  (wdata),
    .fdma_irq_o    (irq)
  );

  tb_dma_model u_dma (
    .ui_clk   (ui_clk),
    .areq_i   (areq),
    .cmd_i    (cmd),
    .wdata_i  (wdata),
    .busy_o   (busy),
    .wvalid_o (wvalid)
  );

  initial begin : clock_gen
    ui_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ui_clk = ~ui_clk;
  end

  task automatic check_value(input string name, input vdma_pkg::beat_t got,
                             input vdma_pkg::beat_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // fifo fill in beats, counted from the pixels and reads seen before each edge
  initial begin : full_monitor
    int   n_wr_pix;
    int   n_rd_beats;
    logic exp_full;
    n_wr_pix   = 0;
    n_rd_beats = 0;
    forever begin
      @(negedge ui_clk);
      exp_full = ((n_wr_pix / `VDMA_PACK_N) - n_rd_beats) == `VDMA_FIFO_BEATS;
      check_value("full_o", vdma_pkg::beat_t'(full), vdma_pkg::beat_t'(exp_full));
      if (pixel_vld && !exp_full) begin
        n_wr_pix++;  // pixels offered while full are dropped
      end
      if (wvalid) begin
        n_rd_beats++;
      end
    end
  end

  task automatic send_pixels();
    int               i;
    int               gap;
    vdma_pkg::pixel_t pix;
    for (i = 0; i < FRAME_PIX; i++) begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) begin
        @(posedge ui_clk);
        pixel_vld <= 1'b0;
      end
      @(posedge ui_clk);
      pix = $random(seed);
      pixel_vld <= 1'b1;
      pixel     <= pix;
      pix_log[n_pix] = pix;
      n_pix++;
    end
    @(posedge ui_clk);
    pixel_vld <= 1'b0;
  endtask

  task automatic check_bursts(input int f, input vdma_pkg::buf_idx_t sel);
    vdma_pkg::addr_t exp_addr;
    vdma_pkg::beat_t exp_beat;
    int              b;
    int              k;
    int              p;
    int              idx;
    check_value("burst count", vdma_pkg::beat_t'(u_dma.n_bursts),
                vdma_pkg::beat_t'((f + 1) * `VDMA_BURSTS));
    for (b = 0; b < `VDMA_BURSTS; b++) begin
      idx = f * `VDMA_BURSTS + b;
      // line pitch from the stride, burst step inside the line
      exp_addr = `VDMA_BASE_ADDR + (vdma_pkg::addr_t'(sel) << `VDMA_OFS_W)
               + vdma_pkg::addr_t'((b / `VDMA_XDIV) * `VDMA_XSTRIDE * (`VDMA_PIX_W / 8))
               + vdma_pkg::addr_t'((b % `VDMA_XDIV) * (`VDMA_XSIZE / `VDMA_XDIV)
                                   * (`VDMA_PIX_W / 8));
      check_value("fdma_cmd_o.addr", vdma_pkg::beat_t'(u_dma.addr_log[idx]),
                  vdma_pkg::beat_t'(exp_addr));
      check_value("fdma_cmd_o.size", vdma_pkg::beat_t'(u_dma.size_log[idx]),
                  vdma_pkg::beat_t'(`VDMA_BURST_BEATS));
      check_value("fdma_areq_o after busy", vdma_pkg::beat_t'(u_dma.areq_log[idx]), '0);
    end
    for (k = 0; k < FRAME_BEATS; k++) begin
      idx = f * FRAME_BEATS + k;
      for (p = 0; p < `VDMA_PACK_N; p++) begin
        exp_beat[p*`VDMA_PIX_W +: `VDMA_PIX_W] = pix_log[idx * `VDMA_PACK_N + p];
      end
      check_value("fdma_wdata_o", u_dma.beat_log[idx], exp_beat);
    end
  endtask

  task automatic run_frame(input int f);
    vdma_pkg::buf_idx_t sel;
    int                 n_irq;
    sel      = vdma_pkg::buf_idx_t'($random(seed));
    exp_sync = (exp_sync == `VDMA_NBUF - 1) ? 0 : exp_sync + 1;
    @(posedge ui_clk);
    buf_sel <= sel;
    fs      <= 1'b1;
    repeat (4) @(posedge ui_clk);
    fs <= 1'b0;
    repeat (36) @(posedge ui_clk);  // pixels start 40 cycles after fs rise
    send_pixels();
    @(negedge ui_clk);
    while (!irq) @(negedge ui_clk);
    check_value("wbuf_o", vdma_pkg::beat_t'(wbuf), vdma_pkg::beat_t'(sel));
    check_value("sync_cnt_o", vdma_pkg::beat_t'(sync_cnt), vdma_pkg::beat_t'(exp_sync));
    n_irq = 0;
    while (irq) begin
      n_irq++;
      @(negedge ui_clk);
    end
    check_value("fdma_irq_o length", vdma_pkg::beat_t'(n_irq),
                vdma_pkg::beat_t'(`VDMA_IRQ_CYC));
    check_bursts(f, sel);
  endtask

  initial begin : stimulus
    int f;
    seed      = 32'hb845_bd1a;
    n_errors  = 0;
    n_checks  = 0;
    n_pix     = 0;
    exp_sync  = 0;
    ui_rstn   = 1'b0;
    fs        = 1'b0;
    pixel_vld = 1'b0;
    pixel     = '0;
    buf_sel   = '0;
    repeat (10) @(posedge ui_clk);
    ui_rstn <= 1'b1;
    @(negedge ui_clk);
    check_value("fdma_areq_o", vdma_pkg::beat_t'(areq), '0);
    check_value("fdma_irq_o", vdma_pkg::beat_t'(irq), '0);
    check_value("sync_cnt_o", vdma_pkg::beat_t'(sync_cnt), '0);
    check_value("wbuf_o", vdma_pkg::beat_t'(wbuf), '0);
    for (f = 0; f < N_FRAMES; f++) begin
      run_frame(f);
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("timeout after %0d cycles, frames did not complete", TIMEOUT_CYC);
    $display("Test failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+common
common/vdma_pkg.sv
design/frame_sync_detect.sv
design/pixel_pack_fifo.sv
write_ctrl/burst_sequencer.sv
design/vdma_frame_writer.sv
test/tb_dma_model.sv
test/tb_vdma_frame_writer.sv

// File: write_ctrl/burst_sequencer.sv
`include "vdma_params.svh"

module burst_sequencer (
  input  logic                ui_clk,
  input  logic                ui_rstn,
  input  logic                frame_start_i,
  input  vdma_pkg::buf_idx_t  buf_sel_i,
  input  vdma_pkg::fifo_cnt_t beat_cnt_i,
  input  logic                busy_i,
  output logic                flush_o,
  output logic                areq_o,
  output vdma_pkg::wr_cmd_t   cmd_o,
  output logic                irq_o,
  output vdma_pkg::buf_idx_t  sync_cnt_o,
  output vdma_pkg::buf_idx_t  wbuf_o
);

  vdma_pkg::burst_state_e                state_q;
  logic [$clog2(`VDMA_RST_CYC)-1:0]      phase_q;   // cycles spent in FLUSH
  logic [$clog2(`VDMA_BURSTS)-1:0]       bcnt_q;    // bursts done this frame
  logic [$clog2(`VDMA_XDIV)-1:0]         div_q;     // burst within the line
  logic [$clog2(`VDMA_IRQ_CYC+1)-1:0]    irq_cnt_q;
  vdma_pkg::ofs_t                        ofs_q;
  vdma_pkg::buf_idx_t                    wbufn_q;   // buffer of current frame
  logic                                  frame_done_q;
  logic                                  data_rdy;

  assign data_rdy = (beat_cnt_i >= vdma_pkg::fifo_cnt_t'(`VDMA_BURST_BEATS));
  assign flush_o  = (state_q == vdma_pkg::FLUSH) && (phase_q < `VDMA_FLUSH_CYC);
  assign irq_o    = (irq_cnt_q != '0);

  assign cmd_o.addr = `VDMA_BASE_ADDR + vdma_pkg::addr_t'({wbufn_q, ofs_q});
  assign cmd_o.size = vdma_pkg::bsize_t'(`VDMA_BURST_BEATS);

  always_ff @(posedge ui_clk) begin
    if (!ui_rstn) begin
      state_q      <= vdma_pkg::IDLE;
      phase_q      <= '0;
      bcnt_q       <= '0;
      div_q        <= '0;
      ofs_q        <= '0;
      wbufn_q      <= '0;
      areq_o       <= 1'b0;
      sync_cnt_o   <= '0;
      frame_done_q <= 1'b0;
    end else begin
      frame_done_q <= 1'b0;
      case (state_q)
        vdma_pkg::IDLE: begin
          phase_q <= '0;
          bcnt_q  <= '0;
          div_q   <= '0;
          ofs_q   <= '0;
          if (frame_start_i) begin
            state_q <= vdma_pkg::FLUSH;
            if (sync_cnt_o == vdma_pkg::buf_idx_t'(`VDMA_NBUF - 1)) begin
              sync_cnt_o <= '0; // ring wrap
            end else begin
              sync_cnt_o <= sync_cnt_o + 1'b1;
            end
          end
        end
        vdma_pkg::FLUSH: begin
          wbufn_q <= buf_sel_i;
          if (phase_q != ($clog2(`VDMA_RST_CYC))'(`VDMA_RST_CYC - 1)) begin
            phase_q <= phase_q + 1'b1;
          end else if (!irq_o) begin
            state_q <= vdma_pkg::REQ; // wait out a pending irq
          end
        end
        vdma_pkg::REQ: begin
          if (!busy_i && data_rdy) begin
            areq_o <= 1'b1;
          end else if (busy_i) begin
            areq_o  <= 1'b0; // engine took the request
            state_q <= vdma_pkg::BUSY;
          end
        end
        vdma_pkg::BUSY: begin
          if (!busy_i) begin
            if (bcnt_q == ($clog2(`VDMA_BURSTS))'(`VDMA_BURSTS - 1)) begin
              state_q      <= vdma_pkg::IDLE;
              frame_done_q <= 1'b1;
            end else begin
              if (div_q != ($clog2(`VDMA_XDIV))'(`VDMA_XDIV - 1)) begin
                ofs_q <= ofs_q + vdma_pkg::ofs_t'(`VDMA_BURST_INC);
                div_q <= div_q + 1'b1;
              end else begin
                ofs_q <= ofs_q + vdma_pkg::ofs_t'(`VDMA_LINE_INC); // skip stride gap
                div_q <= '0;
              end
              bcnt_q  <= bcnt_q + 1'b1;
              state_q <= vdma_pkg::REQ;
            end
          end
        end
        default: state_q <= vdma_pkg::IDLE;
      endcase
    end
  end

  // frame done interrupt and buffer report
  always_ff @(posedge ui_clk) begin
    if (!ui_rstn) begin
      irq_cnt_q <= '0;
      wbuf_o    <= '0;
    end else if (frame_done_q) begin
      irq_cnt_q <= ($clog2(`VDMA_IRQ_CYC+1))'(`VDMA_IRQ_CYC);
      wbuf_o    <= wbufn_q;
    end else if (irq_cnt_q != '0) begin
      irq_cnt_q <= irq_cnt_q - 1'b1;
    end
  end

  a_no_req_in_busy: assert property (@(posedge ui_clk) disable iff (!ui_rstn)
    (state_q == vdma_pkg::BUSY) |-> !areq_o)
    else $error("areq still high during burst");

endmodule
